/* hw/ldq_pkg.sv */
`default_nettype none

package ldq_pkg;

  // ==============================
  // queue geometry and widths
  // ==============================
  localparam int LDQ_SIZE  = 8;
  localparam int LDQ_IDX_W = $clog2(LDQ_SIZE);
  localparam int LDQ_CNT_W = LDQ_IDX_W + 1;
  localparam int CMT_ID_W  = 7;   // msb is the wrap bit
  localparam int PADDR_W   = 32;

  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [LDQ_IDX_W-1:0] ldq_idx_t;

  typedef enum logic [1:0] {
    LDQ_SZ_B,
    LDQ_SZ_H,
    LDQ_SZ_W,
    LDQ_SZ_D
  } ldq_size_t;

  typedef enum logic [2:0] {
    LDQ_FREE        = 3'd0,
    LDQ_WAIT_ISSUE  = 3'd1,
    LDQ_ISSUED      = 3'd2,
    LDQ_EX_DONE     = 3'd3,
    LDQ_WAIT_COMMIT = 3'd4
  } ldq_state_t;

  // ==============================
  // payloads
  // ==============================
  typedef struct packed {
    cmt_id_t   cmt_id;
    ldq_size_t size;
  } ldq_disp_t;

  typedef struct packed {
    ldq_idx_t idx;
    cmt_id_t  cmt_id;
  } ldq_issue_t;

  typedef struct packed {
    logic               valid;
    ldq_idx_t           idx;
    logic               replay;
    logic [PADDR_W-1:0] paddr;
  } ldq_ex_upd_t;

  typedef struct packed {
    logic               valid;
    cmt_id_t            cmt_id;
    ldq_size_t          size;
    logic [PADDR_W-1:0] paddr;
  } ldq_st_chk_t;

  typedef struct packed {
    ldq_state_t         state;
    cmt_id_t            cmt_id;
    ldq_size_t          size;
    logic [PADDR_W-1:0] paddr;
  } ldq_entry_t;

  // bytes touched inside the double word, accesses are naturally aligned
  function automatic logic [7:0] byte_mask(ldq_size_t size, logic [2:0] addr_lo);
    logic [7:0] mask;
    case (size)
      LDQ_SZ_B: mask = 8'h01 << addr_lo;
      LDQ_SZ_H: mask = 8'h03 << {addr_lo[2:1], 1'b0};
      LDQ_SZ_W: mask = 8'h0f << {addr_lo[2], 2'b00};
      default:  mask = 8'hff;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

/* hw/ldq_oldest_pick.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_oldest_pick #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic [ldq_pkg::LDQ_SIZE-1:0] i_req,
  input  ldq_pkg::ldq_idx_t                 i_start_ptr,
  input  payload_t                          i_payload [ldq_pkg::LDQ_SIZE],
  output logic                              o_valid,
  output ldq_pkg::ldq_idx_t                 o_idx,
  output payload_t                          o_payload
);

  import ldq_pkg::*;

  logic [2*LDQ_SIZE-1:0] w_req_dbl;
  logic [LDQ_SIZE-1:0]   w_req_rot;
  logic [LDQ_SIZE-1:0]   w_rot_oh;
  logic [2*LDQ_SIZE-1:0] w_oh_dbl;
  logic [LDQ_SIZE-1:0]   w_sel_oh;

  // rotate so the start pointer sits at bit 0
  assign w_req_dbl = {i_req, i_req} >> i_start_ptr;
  assign w_req_rot = w_req_dbl[LDQ_SIZE-1:0];
  assign w_rot_oh  = w_req_rot & (~w_req_rot + 1'b1);  // lowest set bit
  assign w_oh_dbl  = {w_rot_oh, w_rot_oh} << i_start_ptr;
  assign w_sel_oh  = w_oh_dbl[2*LDQ_SIZE-1:LDQ_SIZE];   // back to entry order

  assign o_valid = |i_req;

  always_comb begin
    o_idx     = '0;
    o_payload = '0;
    for (int i = 0; i < LDQ_SIZE; i++) begin
      o_idx     = o_idx | (ldq_idx_t'(i) & {LDQ_IDX_W{w_sel_oh[i]}});
      o_payload = payload_t'(o_payload | ({$bits(payload_t){w_sel_oh[i]}} & i_payload[i]));
    end
  end

endmodule

`default_nettype wire

/* hw/ldq_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_alloc (
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,
  input  wire logic               i_disp_valid,
  input  wire logic               i_retire,
  output logic                    o_disp_ready,
  output logic                    o_disp_fire,
  output ldq_pkg::ldq_idx_t       o_in_ptr,
  output ldq_pkg::ldq_idx_t       o_out_ptr
);

  import ldq_pkg::*;

  ldq_idx_t               r_in_ptr;
  ldq_idx_t               r_out_ptr;
  logic [LDQ_CNT_W-1:0]   r_count;
  logic                   w_disp_fire;

  assign o_disp_ready = r_count < LDQ_CNT_W'(LDQ_SIZE);
  assign w_disp_fire  = i_disp_valid & o_disp_ready;
  assign o_disp_fire  = w_disp_fire;
  assign o_in_ptr     = r_in_ptr;
  assign o_out_ptr    = r_out_ptr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      if (w_disp_fire) r_in_ptr <= r_in_ptr + 1'b1;   // wraps at 8
      if (i_retire) r_out_ptr <= r_out_ptr + 1'b1;
      case ({w_disp_fire, i_retire})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_count <= LDQ_CNT_W'(LDQ_SIZE));

  a_empty_ptrs: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_count == '0) |-> (r_in_ptr == r_out_ptr));

endmodule

`default_nettype wire

/* hw/ldq_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_entry_array (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  // dispatch
  input  wire logic                  i_disp_fire,
  input  ldq_pkg::ldq_idx_t          i_in_ptr,
  input  ldq_pkg::ldq_disp_t         i_disp,
  // issue and execution result
  input  wire logic                  i_issue_fire,
  input  ldq_pkg::ldq_idx_t          i_issue_idx,
  input  ldq_pkg::ldq_ex_upd_t       i_ex_upd,
  // completion and retire
  input  wire logic                  i_done_fire,
  input  ldq_pkg::ldq_idx_t          i_done_idx,
  input  wire logic                  i_retire,
  input  ldq_pkg::ldq_idx_t          i_retire_idx,
  output ldq_pkg::ldq_entry_t        o_entries [ldq_pkg::LDQ_SIZE]
);

  import ldq_pkg::*;

  for (genvar e = 0; e < LDQ_SIZE; e++) begin : g_entry
    ldq_state_t         r_state;
    cmt_id_t            r_cmt_id;
    ldq_size_t          r_size;
    logic [PADDR_W-1:0] r_paddr;
    logic               w_disp_hit;
    logic               w_issue_hit;
    logic               w_ex_hit;
    logic               w_done_hit;
    logic               w_retire_hit;

    assign w_disp_hit   = i_disp_fire && (i_in_ptr == ldq_idx_t'(e));
    assign w_issue_hit  = i_issue_fire && (i_issue_idx == ldq_idx_t'(e));
    assign w_ex_hit     = i_ex_upd.valid && (i_ex_upd.idx == ldq_idx_t'(e));
    assign w_done_hit   = i_done_fire && (i_done_idx == ldq_idx_t'(e));
    assign w_retire_hit = i_retire && (i_retire_idx == ldq_idx_t'(e));

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state <= LDQ_FREE;
      end else begin
        case (r_state)
          LDQ_FREE:        if (w_disp_hit) r_state <= LDQ_WAIT_ISSUE;
          LDQ_WAIT_ISSUE:  if (w_issue_hit) r_state <= LDQ_ISSUED;
          LDQ_ISSUED: begin
            if (w_ex_hit) r_state <= i_ex_upd.replay ? LDQ_WAIT_ISSUE : LDQ_EX_DONE;
          end
          LDQ_EX_DONE:     if (w_done_hit) r_state <= LDQ_WAIT_COMMIT;
          LDQ_WAIT_COMMIT: if (w_retire_hit) r_state <= LDQ_FREE;
          default:         r_state <= LDQ_FREE;
        endcase
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_disp_hit) begin
        r_cmt_id <= i_disp.cmt_id;
        r_size   <= i_disp.size;
      end
      if (w_ex_hit && !i_ex_upd.replay) r_paddr <= i_ex_upd.paddr;  // address known
    end

    assign o_entries[e] = '{state: r_state, cmt_id: r_cmt_id, size: r_size, paddr: r_paddr};
  end

  a_disp_to_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_fire |-> (o_entries[i_in_ptr].state == LDQ_FREE));

  a_ex_to_issued: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex_upd.valid |-> (o_entries[i_ex_upd.idx].state == LDQ_ISSUED));

endmodule

`default_nettype wire

/* hw/ldq_issue_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_issue_retire (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,
  input  ldq_pkg::ldq_entry_t    i_entries [ldq_pkg::LDQ_SIZE],
  input  ldq_pkg::ldq_idx_t      i_out_ptr,
  input  wire logic              i_issue_ready,
  input  wire logic              i_commit_valid,
  input  ldq_pkg::cmt_id_t       i_commit_cmt_id,
  output logic                   o_issue_valid,
  output ldq_pkg::ldq_issue_t    o_issue,
  output logic                   o_issue_fire,
  output logic                   o_done_valid,
  output ldq_pkg::cmt_id_t       o_done_cmt_id,
  output ldq_pkg::ldq_idx_t      o_done_idx,
  output logic                   o_retire,
  output ldq_pkg::ldq_idx_t      o_retire_idx
);

  import ldq_pkg::*;

  logic [LDQ_SIZE-1:0] w_issue_req;
  logic [LDQ_SIZE-1:0] w_done_req;
  ldq_issue_t          w_issue_payload [LDQ_SIZE];
  cmt_id_t             w_done_payload [LDQ_SIZE];
  ldq_entry_t          w_head;

  for (genvar e = 0; e < LDQ_SIZE; e++) begin : g_req
    assign w_issue_req[e]            = i_entries[e].state == LDQ_WAIT_ISSUE;
    assign w_done_req[e]             = i_entries[e].state == LDQ_EX_DONE;
    assign w_issue_payload[e].idx    = ldq_idx_t'(e);
    assign w_issue_payload[e].cmt_id = i_entries[e].cmt_id;
    assign w_done_payload[e]         = i_entries[e].cmt_id;
  end

  // ==============================
  // issue
  // ==============================
  ldq_oldest_pick #(
    .payload_t (ldq_issue_t)
  ) u_issue_pick (
    .i_req       (w_issue_req),
    .i_start_ptr (i_out_ptr),
    .i_payload   (w_issue_payload),
    .o_valid     (o_issue_valid),
    .o_idx       (),
    .o_payload   (o_issue)
  );

  assign o_issue_fire = o_issue_valid & i_issue_ready;

  // completion report, oldest first, no back-pressure
  ldq_oldest_pick #(
    .payload_t (cmt_id_t)
  ) u_done_pick (
    .i_req       (w_done_req),
    .i_start_ptr (i_out_ptr),
    .i_payload   (w_done_payload),
    .o_valid     (o_done_valid),
    .o_idx       (o_done_idx),
    .o_payload   (o_done_cmt_id)
  );

  // ==============================
  // in-order retire
  // ==============================
  assign w_head       = i_entries[i_out_ptr];
  assign o_retire     = i_commit_valid && (w_head.state == LDQ_WAIT_COMMIT) &&
                        (w_head.cmt_id == i_commit_cmt_id);
  assign o_retire_idx = i_out_ptr;

  a_commit_after_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_commit_valid && (w_head.state != LDQ_FREE) && (w_head.cmt_id == i_commit_cmt_id))
      |-> (w_head.state == LDQ_WAIT_COMMIT));

endmodule

`default_nettype wire

/* hw/ldq_st_haz_check.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_st_haz_check (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,
  input  ldq_pkg::ldq_st_chk_t   i_st_chk,
  input  ldq_pkg::ldq_entry_t    i_entries [ldq_pkg::LDQ_SIZE],
  input  ldq_pkg::ldq_idx_t      i_out_ptr,
  output logic                   o_haz_valid,
  output ldq_pkg::cmt_id_t       o_haz_cmt_id
);

  import ldq_pkg::*;

  logic [LDQ_SIZE-1:0] w_haz_req;
  cmt_id_t             w_cmt_ids [LDQ_SIZE];
  logic                w_haz_any;
  cmt_id_t             w_haz_cmt_id;
  logic [7:0]          w_st_mask;

  // a older than b, low bits compared and reversed across a wrap
  function automatic logic id_older(cmt_id_t a, cmt_id_t b);
    logic same_wrap;
    same_wrap = a[CMT_ID_W-1] == b[CMT_ID_W-1];
    return same_wrap ? (a[CMT_ID_W-2:0] < b[CMT_ID_W-2:0]) :
                       (a[CMT_ID_W-2:0] > b[CMT_ID_W-2:0]);
  endfunction

  assign w_st_mask = byte_mask(i_st_chk.size, i_st_chk.paddr[2:0]);

  for (genvar e = 0; e < LDQ_SIZE; e++) begin : g_haz
    logic w_has_data;
    logic w_same_dw;
    logic w_overlap;

    assign w_has_data = (i_entries[e].state == LDQ_EX_DONE) ||
                        (i_entries[e].state == LDQ_WAIT_COMMIT);
    assign w_same_dw  = i_entries[e].paddr[PADDR_W-1:3] == i_st_chk.paddr[PADDR_W-1:3];
    assign w_overlap  = |(w_st_mask & byte_mask(i_entries[e].size, i_entries[e].paddr[2:0]));
    assign w_haz_req[e] = i_st_chk.valid && w_has_data && w_same_dw && w_overlap &&
                          id_older(i_st_chk.cmt_id, i_entries[e].cmt_id);
    assign w_cmt_ids[e] = i_entries[e].cmt_id;
  end

  ldq_oldest_pick #(
    .payload_t (cmt_id_t)
  ) u_haz_pick (
    .i_req       (w_haz_req),
    .i_start_ptr (i_out_ptr),
    .i_payload   (w_cmt_ids),
    .o_valid     (w_haz_any),
    .o_idx       (),
    .o_payload   (w_haz_cmt_id)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) o_haz_valid <= 1'b0;
    else o_haz_valid <= w_haz_any;
  end

  always_ff @(posedge i_clk) o_haz_cmt_id <= w_haz_cmt_id;

endmodule

`default_nettype wire

/* hw/ldq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_top (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,
  // dispatch
  input  wire logic              i_disp_valid,
  input  ldq_pkg::ldq_disp_t     i_disp,
  output logic                   o_disp_ready,
  // issue to the pipe and its result
  output logic                   o_issue_valid,
  output ldq_pkg::ldq_issue_t    o_issue,
  input  wire logic              i_issue_ready,
  input  ldq_pkg::ldq_ex_upd_t   i_ex_upd,
  // completion and commit
  output logic                   o_done_valid,
  output ldq_pkg::cmt_id_t       o_done_cmt_id,
  input  wire logic              i_commit_valid,
  input  ldq_pkg::cmt_id_t       i_commit_cmt_id,
  // store ordering probe
  input  ldq_pkg::ldq_st_chk_t   i_st_chk,
  output logic                   o_haz_valid,
  output ldq_pkg::cmt_id_t       o_haz_cmt_id
);

  import ldq_pkg::*;

  logic       w_disp_fire;
  ldq_idx_t   w_in_ptr;
  ldq_idx_t   w_out_ptr;
  ldq_entry_t w_entries [LDQ_SIZE];
  logic       w_issue_fire;
  ldq_idx_t   w_done_idx;
  logic       w_retire;
  ldq_idx_t   w_retire_idx;

  ldq_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_retire     (w_retire),
    .o_disp_ready (o_disp_ready),
    .o_disp_fire  (w_disp_fire),
    .o_in_ptr     (w_in_ptr),
    .o_out_ptr    (w_out_ptr)
  );

  ldq_entry_array u_entry_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_fire  (w_disp_fire),
    .i_in_ptr     (w_in_ptr),
    .i_disp       (i_disp),
    .i_issue_fire (w_issue_fire),
    .i_issue_idx  (o_issue.idx),
    .i_ex_upd     (i_ex_upd),
    .i_done_fire  (o_done_valid),
    .i_done_idx   (w_done_idx),
    .i_retire     (w_retire),
    .i_retire_idx (w_retire_idx),
    .o_entries    (w_entries)
  );

  ldq_issue_retire u_issue_retire (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_entries       (w_entries),
    .i_out_ptr       (w_out_ptr),
    .i_issue_ready   (i_issue_ready),
    .i_commit_valid  (i_commit_valid),
    .i_commit_cmt_id (i_commit_cmt_id),
    .o_issue_valid   (o_issue_valid),
    .o_issue         (o_issue),
    .o_issue_fire    (w_issue_fire),
    .o_done_valid    (o_done_valid),
    .o_done_cmt_id   (o_done_cmt_id),
    .o_done_idx      (w_done_idx),
    .o_retire        (w_retire),
    .o_retire_idx    (w_retire_idx)
  );

  ldq_st_haz_check u_st_haz_check (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_st_chk     (i_st_chk),
    .i_entries    (w_entries),
    .i_out_ptr    (w_out_ptr),
    .o_haz_valid  (o_haz_valid),
    .o_haz_cmt_id (o_haz_cmt_id)
  );

endmodule

`default_nettype wire

/* verif/ldq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ldq_tb;

  import ldq_pkg::*;

  localparam int MAX_CYCLES = 400;  // stimulus needs about 110 cycles

  logic        clk = 1'b0;
  logic        reset_n = 1'b0;
  logic        disp_valid = 1'b0;
  ldq_disp_t   disp = '0;
  logic        disp_ready;
  logic        issue_valid;
  ldq_issue_t  issue;
  logic        issue_ready = 1'b0;
  ldq_ex_upd_t ex_upd = '0;
  logic        done_valid;
  cmt_id_t     done_cmt_id;
  logic        commit_valid = 1'b0;
  cmt_id_t     commit_cmt_id = '0;
  ldq_st_chk_t st_chk = '0;
  logic        haz_valid;
  cmt_id_t     haz_cmt_id;

  // reference model, indexed by commit id
  ldq_state_t         mst   [128];
  ldq_idx_t           midx  [128];
  ldq_size_t          msize [128];
  logic [PADDR_W-1:0] maddr [128];
  cmt_id_t            live [$];       // live loads, oldest first
  ldq_idx_t           next_idx = '0;
  int                 exp_count = 0;
  logic               exp_issue_any = 1'b0;
  ldq_issue_t         exp_issue = '0;
  logic               exp_done_any = 1'b0;
  cmt_id_t            exp_done_id = '0;
  logic               exp_haz_valid = 1'b0;
  cmt_id_t            exp_haz_id = '0;
  logic               hold_chk = 1'b0;
  ldq_issue_t         held_issue = '0;

  int     errors = 0;
  int     err_mark = 0;
  int     n_tests = 0;
  int     n_failed = 0;
  int     cycles = 0;
  integer seed = 32'hcdad3848;

  always #50 clk = ~clk;

  ldq_top uut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_disp_valid    (disp_valid),
    .i_disp          (disp),
    .o_disp_ready    (disp_ready),
    .o_issue_valid   (issue_valid),
    .o_issue         (issue),
    .i_issue_ready   (issue_ready),
    .i_ex_upd        (ex_upd),
    .o_done_valid    (done_valid),
    .o_done_cmt_id   (done_cmt_id),
    .i_commit_valid  (commit_valid),
    .i_commit_cmt_id (commit_cmt_id),
    .i_st_chk        (st_chk),
    .o_haz_valid     (haz_valid),
    .o_haz_cmt_id    (haz_cmt_id)
  );

  // load has data, is younger than the store and shares bytes with it
  function automatic logic load_hit(cmt_id_t ld, ldq_st_chk_t st);
    logic [7:0] ld_mask;
    logic [7:0] st_mask;
    ld_mask = byte_mask(msize[ld], maddr[ld][2:0]);
    st_mask = byte_mask(st.size, st.paddr[2:0]);
    return (mst[ld] == LDQ_EX_DONE || mst[ld] == LDQ_WAIT_COMMIT) && (st.cmt_id < ld) &&
           (maddr[ld][PADDR_W-1:3] == st.paddr[PADDR_W-1:3]) && |(ld_mask & st_mask);
  endfunction

  // ==============================
  // reference model
  // ==============================
  always @(posedge clk) begin
    if (!reset_n) begin
      live.delete();
      next_idx      = '0;
      exp_count     = 0;
      exp_issue_any = 1'b0;
      exp_done_any  = 1'b0;
      exp_haz_valid = 1'b0;
      hold_chk      = 1'b0;
    end else begin
      exp_haz_valid = 1'b0;   // probe sees the state before this edge
      foreach (live[i]) begin
        if (st_chk.valid && !exp_haz_valid && load_hit(live[i], st_chk)) begin
          exp_haz_valid = 1'b1;
          exp_haz_id    = live[i];
        end
      end
      hold_chk   = exp_issue_any && !issue_ready;
      held_issue = exp_issue;
      if (commit_valid && live.size() > 0 && live[0] == commit_cmt_id &&
          mst[live[0]] == LDQ_WAIT_COMMIT) begin
        mst[live[0]] = LDQ_FREE;
        void'(live.pop_front());
      end
      if (exp_done_any) mst[exp_done_id] = LDQ_WAIT_COMMIT;
      foreach (live[i]) begin
        if (ex_upd.valid && midx[live[i]] == ex_upd.idx && mst[live[i]] == LDQ_ISSUED) begin
          mst[live[i]] = ex_upd.replay ? LDQ_WAIT_ISSUE : LDQ_EX_DONE;
          if (!ex_upd.replay) maddr[live[i]] = ex_upd.paddr;
        end
      end
      if (issue_ready && exp_issue_any) mst[exp_issue.cmt_id] = LDQ_ISSUED;
      if (disp_valid && exp_count < LDQ_SIZE) begin
        mst[disp.cmt_id]   = LDQ_WAIT_ISSUE;
        midx[disp.cmt_id]  = next_idx;
        msize[disp.cmt_id] = disp.size;
        live.push_back(disp.cmt_id);
        next_idx = next_idx + 1'b1;
      end
      exp_count     = live.size();
      exp_issue_any = 1'b0;
      exp_done_any  = 1'b0;
      foreach (live[i]) begin
        if (!exp_issue_any && mst[live[i]] == LDQ_WAIT_ISSUE) begin
          exp_issue_any = 1'b1;
          exp_issue     = '{idx: midx[live[i]], cmt_id: live[i]};
        end
        if (!exp_done_any && mst[live[i]] == LDQ_EX_DONE) begin
          exp_done_any = 1'b1;
          exp_done_id  = live[i];
        end
      end
    end
  end

  // ==============================
  // checks
  // ==============================
  a_disp_ready: assert property (@(posedge clk) disable iff (!reset_n)
    disp_ready == (exp_count < LDQ_SIZE))
    else report_mismatch("o_disp_ready", $sampled(disp_ready), $sampled(exp_count) < LDQ_SIZE);
  a_issue_valid: assert property (@(posedge clk) disable iff (!reset_n)
    issue_valid == exp_issue_any)
    else report_mismatch("o_issue_valid", $sampled(issue_valid), $sampled(exp_issue_any));
  a_issue_oldest: assert property (@(posedge clk) disable iff (!reset_n)
    issue_valid |-> issue == exp_issue)
    else report_mismatch("o_issue", $sampled(issue), $sampled(exp_issue));
  a_issue_hold: assert property (@(posedge clk) disable iff (!reset_n)
    hold_chk |-> (issue_valid && issue == held_issue))
    else report_mismatch("o_issue", $sampled(issue), $sampled(held_issue));
  a_done_valid: assert property (@(posedge clk) disable iff (!reset_n)
    done_valid == exp_done_any)
    else report_mismatch("o_done_valid", $sampled(done_valid), $sampled(exp_done_any));
  a_done_id: assert property (@(posedge clk) disable iff (!reset_n)
    done_valid |-> done_cmt_id == exp_done_id)
    else report_mismatch("o_done_cmt_id", $sampled(done_cmt_id), $sampled(exp_done_id));
  a_haz_valid: assert property (@(posedge clk) disable iff (!reset_n)
    haz_valid == exp_haz_valid)
    else report_mismatch("o_haz_valid", $sampled(haz_valid), $sampled(exp_haz_valid));
  a_haz_id: assert property (@(posedge clk) disable iff (!reset_n)
    haz_valid |-> haz_cmt_id == exp_haz_id)
    else report_mismatch("o_haz_cmt_id", $sampled(haz_cmt_id), $sampled(exp_haz_id));

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("[FAIL] at %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic end_test(string name);
    n_tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors", n_tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ==============================
  // stimulus tasks
  // ==============================
  task automatic dispatch(cmt_id_t id);
    disp_valid = 1'b1;
    disp       = '{cmt_id: id, size: ldq_size_t'($unsigned($random(seed)) % 3)};
    @(posedge clk);
    #10 disp_valid = 1'b0;
  endtask

  task automatic send_result(cmt_id_t id, logic replay, logic [PADDR_W-1:0] addr);
    ex_upd = '{valid: 1'b1, idx: midx[id], replay: replay, paddr: addr};
    @(posedge clk);
    #10 ex_upd.valid = 1'b0;
  endtask

  task automatic complete(cmt_id_t id);
    logic               replay;
    logic [2:0]         off;
    logic [PADDR_W-1:0] addr;
    off = 3'($random(seed) & 3);  // loads stay in the low word
    case (msize[id])
      LDQ_SZ_H: off[0] = 1'b0;
      LDQ_SZ_W: off = '0;
      default:  off = off;
    endcase
    addr   = 32'h0000_1000 | PADDR_W'(off);
    replay = 1'b1;
    while (replay) begin
      replay = (($random(seed) & 3) == 0);
      send_result(id, replay, addr);
      while (replay && mst[id] != LDQ_ISSUED) begin
        @(posedge clk);
        #10;
      end
    end
  endtask

  task automatic commit(cmt_id_t id);
    while (mst[id] != LDQ_WAIT_COMMIT) begin
      @(posedge clk);
      #10;
    end
    commit_valid  = 1'b1;
    commit_cmt_id = id;
    @(posedge clk);
    #10 commit_valid = 1'b0;
  endtask

  task automatic probe(cmt_id_t id, ldq_size_t size, logic [PADDR_W-1:0] addr);
    st_chk = '{valid: 1'b1, cmt_id: id, size: size, paddr: addr};
    @(posedge clk);
    #10 st_chk.valid = 1'b0;
    @(posedge clk);   // result checked at this edge
    #10;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    repeat (5) @(posedge clk);
    #10 reset_n = 1'b1;
    @(posedge clk);
    #10;
    end_test("reset state");

    issue_ready = 1'b1;
    for (int k = 0; k < LDQ_SIZE; k++) dispatch(cmt_id_t'(k));
    dispatch(cmt_id_t'(8));   // queue full, not taken
    repeat (2) @(posedge clk);
    #10;
    end_test("fill and in-order issue");

    issue_ready = 1'b0;
    send_result(cmt_id_t'(2), 1'b1, '0);
    send_result(cmt_id_t'(5), 1'b1, '0);
    repeat (3) @(posedge clk);
    #10;
    end_test("issue held under stall");

    issue_ready = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    end_test("replay reissue");

    for (int k = 0; k < LDQ_SIZE; k++) complete(cmt_id_t'(k));
    for (int k = 0; k < 4; k++) commit(cmt_id_t'(k));
    @(posedge clk);
    #10;
    end_test("completion and commit");

    probe(cmt_id_t'(3), LDQ_SZ_D, 32'h0000_1000);   // hits load 4
    probe(cmt_id_t'(3), LDQ_SZ_W, 32'h0000_1004);   // upper word only
    probe(cmt_id_t'(10), LDQ_SZ_D, 32'h0000_1000);  // younger store
    probe(cmt_id_t'(5), LDQ_SZ_D, 32'h0000_1000);   // hits load 6
    end_test("store hazard");

    // drain
    for (int k = 4; k < LDQ_SIZE; k++) commit(cmt_id_t'(k));
    @(posedge clk);
    #10;

    $display("tests %0d, failed tests %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/ldq_pkg.sv
hw/ldq_oldest_pick.sv
hw/ldq_alloc.sv
hw/ldq_entry_array.sv
hw/ldq_issue_retire.sv
hw/ldq_st_haz_check.sv
hw/ldq_top.sv
verif/ldq_tb.sv

/* Bender.yml */
package:
  name: ldq

sources:
  - target: rtl
    files:
      - hw/ldq_pkg.sv
      - hw/ldq_oldest_pick.sv
      - hw/ldq_alloc.sv
      - hw/ldq_entry_array.sv
      - hw/ldq_issue_retire.sv
      - hw/ldq_st_haz_check.sv
      - hw/ldq_top.sv
  - target: test
    files:
      - verif/ldq_tb.sv
